/* logic/saturn_mem_settings.svh */
`ifndef SATURN_MEM_SETTINGS_SVH
`define SATURN_MEM_SETTINGS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// ddr word address and data
`define DDR_AW 27
`define DDR_DW 32
// one enable per ddr byte lane
`define DDR_BEW (`DDR_DW / 8)

// cpu side address
`define CPU_AW 25

// host download port
`define LOAD_AW 25
`define LOAD_DW 16

//////////////////////////////
// codes
//////////////////////////////

// download index of all ones means boot code, not a cartridge
`define CODE_INDEX 8'hff

// upper address prefix per region
`define REGION_ROM 8'd0
`define REGION_RAML 8'd1
`define REGION_RAMH 8'd2

`endif

/* logic/saturn_mem_pkg.sv */
`include "saturn_mem_settings.svh"

package saturn_mem_pkg;

	//////////////////////////////
	// cpu side regions
	//////////////////////////////

	// decoded from the three chip selects
	// none when no select is low
	typedef enum logic [1:0] {
		MEM_ROM  = 2'd0,
		MEM_RAML = 2'd1,
		MEM_RAMH = 2'd2,
		MEM_NONE = 2'd3
	} mem_region_t;

	//////////////////////////////
	// ddr port
	//////////////////////////////

	// word address into ddr
	typedef logic [`DDR_AW-1:0] ddr_addr_t;

	// read and write data
	typedef logic [`DDR_DW-1:0] ddr_word_t;

	// byte lane enables
	// bit 0 is the low byte
	typedef logic [`DDR_BEW-1:0] ddr_be_t;

endpackage

/* logic/host_load_pkg.sv */
`include "saturn_mem_settings.svh"

package host_load_pkg;

	// loader fsm
	// idle waits for a host word
	// req holds until the port is free
	// wait covers the ddr busy time
	typedef enum logic [1:0] {
		LOAD_IDLE = 2'd0,
		LOAD_REQ  = 2'd1,
		LOAD_WAIT = 2'd2
	} load_state_t;

	// byte address from the host
	typedef logic [`LOAD_AW-1:0] load_addr_t;

	// one download word
	typedef logic [`LOAD_DW-1:0] load_word_t;

endpackage

/* logic/cart_loader.sv */
`timescale 1ns/1ps

`include "saturn_mem_settings.svh"

module cart_loader
	import saturn_mem_pkg::*, host_load_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  load_addr_t  ioctl_addr,
	input  load_word_t  ioctl_data,
	input  logic        load_busy,
	output logic        ioctl_wait,
	output logic        cart_active,
	output logic        load_req,
	output ddr_addr_t   load_addr,
	output ddr_word_t   load_wdata,
	output ddr_be_t     load_be
);

	load_state_t state;
	// busy of the previous cycle for fall detect
	logic        busy_q;
	logic        accept;

	// code downloads go elsewhere
	assign cart_active = ioctl_download && (ioctl_index != `CODE_INDEX);
	assign accept = (state == LOAD_IDLE) && cart_active && ioctl_wr;

	// single strobe once the port is ours and idle
	assign load_req = (state == LOAD_REQ) && !load_busy;

	// halfword writes only
	assign load_be = ddr_be_t'(2'b11);

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= LOAD_IDLE;
			ioctl_wait <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			busy_q <= load_busy;
			case (state)
				LOAD_IDLE: begin
					// stall host until the word is in memory
					if (accept) begin
						state <= LOAD_REQ;
						ioctl_wait <= 1'b1;
					end
				end
				LOAD_REQ: begin
					if (!load_busy)
						state <= LOAD_WAIT;
				end
				LOAD_WAIT: begin
					// busy rises after the strobe, done on its fall
					if (busy_q && !load_busy) begin
						state <= LOAD_IDLE;
						ioctl_wait <= 1'b0;
					end
				end
				default: state <= LOAD_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// word capture
	//////////////////////////////

	// host sends big endian bytes, swap into the low lanes
	// byte address to word address at the rom base
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			load_wdata <= ddr_word_t'({ioctl_data[7:0], ioctl_data[15:8]});
			load_addr <= {`REGION_ROM, {(`DDR_AW - 8){1'b0}}} |
				ddr_addr_t'(ioctl_addr[`LOAD_AW-1:1]);
		end
	end

endmodule

/* logic/cpu_mem_mapper.sv */
`timescale 1ns/1ps

`include "saturn_mem_settings.svh"

module cpu_mem_mapper
	import saturn_mem_pkg::*;
(
	input  logic              clk_sys,
	input  logic              rst,
	input  logic              rom_cs_n,
	input  logic              raml_cs_n,
	input  logic              ramh_cs_n,
	input  logic              mem_rd_n,
	input  ddr_be_t           mem_dqm_n,
	input  logic [`CPU_AW-1:0] mem_a,
	input  ddr_word_t         mem_do,
	input  logic              cpu_busy,
	input  ddr_word_t         ddr_dout,
	output ddr_word_t         mem_di,
	output logic              mem_wait_n,
	output logic              cpu_req,
	output logic              cpu_rd,
	output logic              cpu_16b,
	output ddr_addr_t         cpu_addr,
	output ddr_word_t         cpu_wdata,
	output ddr_be_t           cpu_be
);

	// access sequence
	// done holds until the cpu drops its selects
	typedef enum logic [1:0] {
		CPU_IDLE = 2'd0,
		CPU_REQ  = 2'd1,
		CPU_WAIT = 2'd2,
		CPU_DONE = 2'd3
	} cpu_state_t;

	cpu_state_t  state;
	mem_region_t region;
	logic        access;
	logic        busy_q;

	//////////////////////////////
	// decode
	//////////////////////////////

	// rom wins if several selects are low
	always_comb begin
		if (!rom_cs_n)
			region = MEM_ROM;
		else if (!raml_cs_n)
			region = MEM_RAML;
		else if (!ramh_cs_n)
			region = MEM_RAMH;
		else
			region = MEM_NONE;
	end

	// a select plus a read or any byte write
	assign access = (region != MEM_NONE) && (!mem_rd_n || !(&mem_dqm_n));

	// ddr placement per region
	always_comb begin
		case (region)
			MEM_ROM:  cpu_addr = {`REGION_ROM, 1'b0, mem_a[18:1]};
			MEM_RAML: cpu_addr = {`REGION_RAML, mem_a[19:1]};
			// 32 bit region, even word addresses only
			MEM_RAMH: cpu_addr = {`REGION_RAMH, mem_a[19:2], 1'b0};
			default:  cpu_addr = '0;
		endcase
	end

	assign cpu_16b = (region == MEM_ROM) || (region == MEM_RAML);
	assign cpu_rd = !mem_rd_n;
	assign cpu_be = ~mem_dqm_n;
	// cpu holds its bus so data goes straight through
	assign cpu_wdata = mem_do;
	assign cpu_req = (state == CPU_REQ) && !cpu_busy;

	//////////////////////////////
	// handshake
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= CPU_IDLE;
			mem_wait_n <= 1'b1;
			busy_q <= 1'b0;
		end else begin
			busy_q <= cpu_busy;
			case (state)
				CPU_IDLE: begin
					// stall the cpu right away
					if (access) begin
						state <= CPU_REQ;
						mem_wait_n <= 1'b0;
					end
				end
				CPU_REQ: begin
					// stays here while the loader holds the port
					if (!cpu_busy)
						state <= CPU_WAIT;
				end
				CPU_WAIT: begin
					if (busy_q && !cpu_busy) begin
						state <= CPU_DONE;
						mem_wait_n <= 1'b1;
					end
				end
				CPU_DONE: begin
					// one request per access
					if (!access)
						state <= CPU_IDLE;
				end
				default: state <= CPU_IDLE;
			endcase
		end
	end

	// read data is valid only on the busy fall
	always_ff @(posedge clk_sys) begin
		if (state == CPU_WAIT && busy_q && !cpu_busy)
			mem_di <= ddr_dout;
	end

endmodule

/* logic/ddr_arbiter.sv */
`timescale 1ns/1ps

module ddr_arbiter
	import saturn_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst,
	input  logic      cart_active,
	input  logic      load_req,
	input  ddr_addr_t load_addr,
	input  ddr_word_t load_wdata,
	input  ddr_be_t   load_be,
	input  logic      cpu_req,
	input  ddr_addr_t cpu_addr,
	input  ddr_word_t cpu_wdata,
	input  ddr_be_t   cpu_be,
	input  logic      cpu_rd,
	input  logic      cpu_16b,
	input  logic      ddr_busy,
	output logic      load_busy,
	output logic      cpu_busy,
	output ddr_addr_t ddr_addr,
	output ddr_word_t ddr_din,
	output ddr_be_t   ddr_wr,
	output logic      ddr_rd,
	output logic      ddr_16b
);

	typedef enum logic {
		OWN_CPU  = 1'b0,
		OWN_LOAD = 1'b1
	} owner_t;

	owner_t owner;
	logic   load_go;
	logic   cpu_go;

	// handover only between transfers
	// loader takes the port for the whole download
	always_ff @(posedge clk_sys) begin
		if (rst)
			owner <= OWN_CPU;
		else if (!ddr_busy && !load_req && !cpu_req)
			owner <= cart_active ? OWN_LOAD : OWN_CPU;
	end

	//////////////////////////////
	// routing
	//////////////////////////////

	// the side without the port sees busy
	// held off cpu keeps mem_wait_n low this way
	assign load_busy = (owner == OWN_LOAD) ? ddr_busy : 1'b1;
	assign cpu_busy = (owner == OWN_CPU) ? ddr_busy : 1'b1;

	// strobes pass only for the owner
	assign load_go = (owner == OWN_LOAD) && load_req;
	assign cpu_go = (owner == OWN_CPU) && cpu_req;

	assign ddr_addr = (owner == OWN_LOAD) ? load_addr : cpu_addr;
	assign ddr_din = (owner == OWN_LOAD) ? load_wdata : cpu_wdata;

	// enables only in the strobe cycle
	always_comb begin
		if (load_go)
			ddr_wr = load_be;
		else if (cpu_go && !cpu_rd)
			ddr_wr = cpu_be;
		else
			ddr_wr = '0;
	end

	// loader never reads
	assign ddr_rd = cpu_go && cpu_rd;
	// loader words are always halfwords
	assign ddr_16b = (owner == OWN_LOAD) ? 1'b1 : cpu_16b;

endmodule

/* logic/saturn_mem_top.sv */
`timescale 1ns/1ps

`include "saturn_mem_settings.svh"

module saturn_mem_top
	import saturn_mem_pkg::*, host_load_pkg::*;
(
	input  logic              clk_sys,
	input  logic              rst,
	// host download
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  load_addr_t        ioctl_addr,
	input  load_word_t        ioctl_data,
	output logic              ioctl_wait,
	// cpu bus
	input  logic              rom_cs_n,
	input  logic              raml_cs_n,
	input  logic              ramh_cs_n,
	input  logic              mem_rd_n,
	input  ddr_be_t           mem_dqm_n,
	input  logic [`CPU_AW-1:0] mem_a,
	input  ddr_word_t         mem_do,
	output ddr_word_t         mem_di,
	output logic              mem_wait_n,
	// ddr port
	output ddr_addr_t         ddr_addr,
	output ddr_word_t         ddr_din,
	output ddr_be_t           ddr_wr,
	output logic              ddr_rd,
	output logic              ddr_16b,
	input  logic              ddr_busy,
	input  ddr_word_t         ddr_dout
);

	// loader side
	logic      cart_active;
	logic      load_req;
	logic      load_busy;
	ddr_addr_t load_addr;
	ddr_word_t load_wdata;
	ddr_be_t   load_be;

	// cpu side
	logic      cpu_req;
	logic      cpu_rd;
	logic      cpu_16b;
	logic      cpu_busy;
	ddr_addr_t cpu_addr;
	ddr_word_t cpu_wdata;
	ddr_be_t   cpu_be;

	//////////////////////////////
	// requesters
	//////////////////////////////

	cart_loader u_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.load_busy      (load_busy),
		.ioctl_wait     (ioctl_wait),
		.cart_active    (cart_active),
		.load_req       (load_req),
		.load_addr      (load_addr),
		.load_wdata     (load_wdata),
		.load_be        (load_be)
	);

	cpu_mem_mapper u_mapper (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.rom_cs_n   (rom_cs_n),
		.raml_cs_n  (raml_cs_n),
		.ramh_cs_n  (ramh_cs_n),
		.mem_rd_n   (mem_rd_n),
		.mem_dqm_n  (mem_dqm_n),
		.mem_a      (mem_a),
		.mem_do     (mem_do),
		.cpu_busy   (cpu_busy),
		.ddr_dout   (ddr_dout),
		.mem_di     (mem_di),
		.mem_wait_n (mem_wait_n),
		.cpu_req    (cpu_req),
		.cpu_rd     (cpu_rd),
		.cpu_16b    (cpu_16b),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_be     (cpu_be)
	);

	//////////////////////////////
	// shared port
	//////////////////////////////

	ddr_arbiter u_arbiter (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.cart_active (cart_active),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_wdata  (load_wdata),
		.load_be     (load_be),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_be      (cpu_be),
		.cpu_rd      (cpu_rd),
		.cpu_16b     (cpu_16b),
		.ddr_busy    (ddr_busy),
		.load_busy   (load_busy),
		.cpu_busy    (cpu_busy),
		.ddr_addr    (ddr_addr),
		.ddr_din     (ddr_din),
		.ddr_wr      (ddr_wr),
		.ddr_rd      (ddr_rd),
		.ddr_16b     (ddr_16b)
	);

endmodule

/* test/saturn_mem_properties.sv */
`timescale 1ns/1ps

`include "saturn_mem_settings.svh"

module saturn_mem_properties
	import saturn_mem_pkg::*, host_load_pkg::*;
(
	input logic        clk_sys,
	input logic        rst,
	input logic        ddr_busy,
	input logic        ddr_rd,
	input ddr_be_t     ddr_wr,
	input logic        ioctl_download,
	input logic [7:0]  ioctl_index,
	input logic        ioctl_wr,
	input logic        ioctl_wait,
	input load_state_t load_state,
	input logic        mem_wait_n
);

	// failed assertions so far
	int fail_count = 0;

	// one transfer at a time on the port
	strobe_idle: assert property (@(posedge clk_sys) disable iff (rst)
		ddr_busy |-> (!ddr_rd && ddr_wr == '0))
	else begin
		fail_count++;
		$error("ddr strobe issued while ddr_busy is high");
	end

	// host stalled right after a cartridge word
	// loader fsm moves on to its request
	wait_rise: assert property (@(posedge clk_sys) disable iff (rst)
		(ioctl_wr && !ioctl_wait && ioctl_download && ioctl_index != `CODE_INDEX)
		|=> (ioctl_wait && load_state == LOAD_REQ))
	else begin
		fail_count++;
		$error("ioctl_wait did not rise after an accepted cartridge write");
	end

	// cpu never stalled by reset
	reset_wait: assert property (@(posedge clk_sys) rst |=> mem_wait_n)
	else begin
		fail_count++;
		$error("mem_wait_n low during reset");
	end

endmodule

bind saturn_mem_top saturn_mem_properties u_props (
	.clk_sys        (clk_sys),
	.rst            (rst),
	.ddr_busy       (ddr_busy),
	.ddr_rd         (ddr_rd),
	.ddr_wr         (ddr_wr),
	.ioctl_download (ioctl_download),
	.ioctl_index    (ioctl_index),
	.ioctl_wr       (ioctl_wr),
	.ioctl_wait     (ioctl_wait),
	.load_state     (u_loader.state),
	.mem_wait_n     (mem_wait_n)
);

/* test/saturn_mem_tb.sv */
`timescale 1ns/1ps

`include "saturn_mem_settings.svh"

module saturn_mem_tb
	import saturn_mem_pkg::*;
();

	typedef enum logic [1:0] {
		OP_LOAD,
		OP_READ,
		OP_WRITE,
		OP_HELD_READ
	} op_kind_t;

	// one table row, data low half is the download word for loads
	typedef struct {
		op_kind_t    kind;
		logic [7:0]  index;
		mem_region_t region;
		logic [24:0] addr;
		ddr_word_t   data;
		ddr_be_t     mask;
		ddr_word_t   exp_val;
	} op_t;

	logic        clk_sys;
	logic        rst;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic        ioctl_wait;
	logic        rom_cs_n;
	logic        raml_cs_n;
	logic        ramh_cs_n;
	logic        mem_rd_n;
	ddr_be_t     mem_dqm_n;
	logic [24:0] mem_a;
	ddr_word_t   mem_do;
	ddr_word_t   mem_di;
	logic        mem_wait_n;
	ddr_addr_t   ddr_addr;
	ddr_word_t   ddr_din;
	ddr_be_t     ddr_wr;
	logic        ddr_rd;
	logic        ddr_16b;
	logic        ddr_busy;
	ddr_word_t   ddr_dout;

	op_t       ops[$];
	// memory model state
	ddr_word_t ddr_mem [ddr_addr_t];
	ddr_addr_t last_addr;
	logic      last_16b;
	ddr_word_t rd_word;
	int        ddr_ops;
	int        busy_len;
	integer    seed;
	int        cycles;
	int        cycle_limit;
	int        checks;
	int        errors;

	saturn_mem_top DUT (.*);

	always #2 clk_sys = ~clk_sys;

	//////////////////////////////
	// ddr memory model
	//////////////////////////////

	// strobe seen on the rising edge, busy from the next cycle on
	always begin
		@(posedge clk_sys);
		if (!rst && (ddr_rd || ddr_wr != '0)) begin
			last_addr = ddr_addr;
			last_16b = ddr_16b;
			ddr_ops++;
			rd_word = ddr_mem.exists(ddr_addr) ? ddr_mem[ddr_addr] : '0;
			for (int i = 0; i < 4; i++)
				if (ddr_wr[i])
					rd_word[8*i +: 8] = ddr_din[8*i +: 8];
			if (ddr_wr != '0)
				ddr_mem[ddr_addr] = rd_word;
			// halfword reads give the low half only
			if (ddr_16b)
				rd_word[31:16] = '0;
			busy_len = 1 + ($unsigned($random(seed)) % 4);
			@(negedge clk_sys);
			ddr_busy = 1'b1;
			repeat (busy_len)
				@(negedge clk_sys);
			ddr_dout = rd_word;
			ddr_busy = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the DUT did not finish within %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic add_op(input op_kind_t kind, input logic [7:0] index,
		input mem_region_t region, input logic [24:0] addr, input ddr_word_t data,
		input ddr_be_t mask, input ddr_word_t exp_val);
		op_t op;
		op.kind = kind;
		op.index = index;
		op.region = region;
		op.addr = addr;
		op.data = data;
		op.mask = mask;
		op.exp_val = exp_val;
		ops.push_back(op);
	endtask

	task automatic compare_value(input string what, input ddr_word_t got,
		input ddr_word_t exp_val);
		checks++;
		assert (got === exp_val) else begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp_val);
		end
	endtask

	// region prefix sits in the top 8 of 27 address bits
	function automatic ddr_addr_t expected_ddr_addr(input mem_region_t region,
		input logic [24:0] a);
		case (region)
			MEM_RAML: return (ddr_addr_t'(`REGION_RAML) << 19) | ddr_addr_t'(a[19:1]);
			MEM_RAMH: return (ddr_addr_t'(`REGION_RAMH) << 19) | ddr_addr_t'({a[19:2], 1'b0});
			default:  return (ddr_addr_t'(`REGION_ROM) << 19) | ddr_addr_t'(a[18:1]);
		endcase
	endfunction

	task automatic load_word(input logic [7:0] index, input logic [24:0] addr,
		input logic [15:0] data);
		int ops_before;
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		ioctl_index = index;
		@(negedge clk_sys);
		ioctl_wr = 1'b1;
		ioctl_addr = addr;
		ioctl_data = data;
		ops_before = ddr_ops;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (index == `CODE_INDEX) begin
			// boot code skips the cartridge path
			repeat (6) begin
				compare_value("ioctl_wait on code download", ioctl_wait, 0);
				@(negedge clk_sys);
			end
			compare_value("ddr ops on code download", ddr_ops, ops_before);
		end else begin
			compare_value("ioctl_wait after write", ioctl_wait, 1);
			while (ioctl_wait !== 1'b0)
				@(negedge clk_sys);
			compare_value("load ddr address", last_addr, expected_ddr_addr(MEM_ROM, addr));
		end
		ioctl_download = 1'b0;
	endtask

	task automatic cpu_access(input op_t op);
		// cartridge download takes the port first
		if (op.kind == OP_HELD_READ) begin
			@(negedge clk_sys);
			ioctl_download = 1'b1;
			ioctl_index = 8'h00;
		end
		@(negedge clk_sys);
		rom_cs_n = (op.region != MEM_ROM);
		raml_cs_n = (op.region != MEM_RAML);
		ramh_cs_n = (op.region != MEM_RAMH);
		mem_a = op.addr;
		mem_rd_n = (op.kind == OP_WRITE);
		mem_dqm_n = (op.kind == OP_WRITE) ? ~op.mask : 4'hf;
		mem_do = op.data;
		@(negedge clk_sys);
		compare_value("mem_wait_n after access start", mem_wait_n, 0);
		if (op.kind == OP_HELD_READ) begin
			repeat (8) begin
				@(negedge clk_sys);
				compare_value("mem_wait_n during download", mem_wait_n, 0);
			end
			ioctl_download = 1'b0;
		end
		while (mem_wait_n !== 1'b1)
			@(negedge clk_sys);
		if (op.kind != OP_WRITE)
			compare_value("mem_di", mem_di, op.exp_val);
		compare_value("cpu ddr address", last_addr, expected_ddr_addr(op.region, op.addr));
		compare_value("ddr_16b", last_16b, op.region != MEM_RAMH);
		// bus released for a cycle
		rom_cs_n = 1'b1;
		raml_cs_n = 1'b1;
		ramh_cs_n = 1'b1;
		mem_rd_n = 1'b1;
		mem_dqm_n = 4'hf;
		@(negedge clk_sys);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		clk_sys = 1'b0;
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		rom_cs_n = 1'b1;
		raml_cs_n = 1'b1;
		ramh_cs_n = 1'b1;
		mem_rd_n = 1'b1;
		mem_dqm_n = 4'hf;
		mem_a = '0;
		mem_do = '0;
		ddr_busy = 1'b0;
		ddr_dout = '0;
		seed = 32'h89cd7553;
		// cartridge words, stored byte swapped
		add_op(OP_LOAD, 8'h00, MEM_ROM, 25'h0000100, 32'h0000a1b2, 4'b0011, 32'h0);
		add_op(OP_LOAD, 8'h00, MEM_ROM, 25'h0002468, 32'h00001357, 4'b0011, 32'h0);
		add_op(OP_LOAD, 8'h01, MEM_ROM, 25'h007fffe, 32'h0000cafe, 4'b0011, 32'h0);
		// boot code on the same address must not land
		add_op(OP_LOAD, `CODE_INDEX, MEM_ROM, 25'h0000100, 32'h0000dead, 4'b0011, 32'h0);
		add_op(OP_READ, 8'h00, MEM_ROM, 25'h0000100, 32'h0, 4'b0000, 32'h0000b2a1);
		add_op(OP_READ, 8'h00, MEM_ROM, 25'h007fffe, 32'h0, 4'b0000, 32'h0000feca);
		// low ram halfword, upper data lanes masked off
		add_op(OP_WRITE, 8'h00, MEM_RAML, 25'h0004a20, 32'hffff5aa5, 4'b0011, 32'h0);
		add_op(OP_READ, 8'h00, MEM_RAML, 25'h0004a20, 32'h0, 4'b0000, 32'h00005aa5);
		// high ram full word then a single lane
		add_op(OP_WRITE, 8'h00, MEM_RAMH, 25'h0000104, 32'h11223344, 4'b1111, 32'h0);
		add_op(OP_WRITE, 8'h00, MEM_RAMH, 25'h0000104, 32'haabbccdd, 4'b0100, 32'h0);
		add_op(OP_READ, 8'h00, MEM_RAMH, 25'h0000104, 32'h0, 4'b0000, 32'h11bb3344);
		add_op(OP_HELD_READ, 8'h00, MEM_ROM, 25'h0002468, 32'h0, 4'b0000, 32'h00005713);
		cycle_limit = ops.size() * 40 + 20;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
		foreach (ops[i]) begin
			if (ops[i].kind == OP_LOAD)
				load_word(ops[i].index, ops[i].addr, ops[i].data[15:0]);
			else
				cpu_access(ops[i]);
		end
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, DUT.u_props.fail_count);
		if (errors == 0 && DUT.u_props.fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+logic
logic/saturn_mem_pkg.sv
logic/host_load_pkg.sv
logic/cart_loader.sv
logic/cpu_mem_mapper.sv
logic/ddr_arbiter.sv
logic/saturn_mem_top.sv
test/saturn_mem_properties.sv
test/saturn_mem_tb.sv

/* Bender.yml */
package:
  name: saturn_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/saturn_mem_pkg.sv
      - logic/host_load_pkg.sv
      - logic/cart_loader.sv
      - logic/cpu_mem_mapper.sv
      - logic/ddr_arbiter.sv
      - logic/saturn_mem_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/saturn_mem_properties.sv
      - test/saturn_mem_tb.sv
